// ==== project.f ====
+incdir+verilog
verilog/simd_op_pkg.sv
verilog/simd_lane_pkg.sv
verilog/simd_op_decode.sv
verilog/simd_lane_adder.sv
verilog/simd_lane_compare.sv
verilog/simd_alu_top.sv
bench/simd_alu_checker.sv
bench/simd_alu_tb.sv

// ==== Makefile ====
# Verilator build for the packed-SIMD unit and its testbench
VERILATOR ?= verilator
VFLAGS    ?= --timing --timescale 1ns/1ns
TOP       ?= simd_alu_tb
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  := RESULT: FAIL

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o $(TOP)
	./$(OBJ_DIR)/$(TOP) > $(LOG) 2>&1 || echo "$(FAIL_MSG)" >> $(LOG)
	cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== bench/simd_alu_stimulus.txt ====
// op width operand_a operand_b expected_result expected_ov
// op and width use the enum codes of simd_op_pkg, width 0 is 8-bit lanes
00 0 7f01ff80 01ffff80 8000fe00 0
00 1 1234ffff 00010001 12350000 0
01 0 00108005 01207f05 fff00100 0
01 1 00050000 00010001 0004ffff 0
02 0 7f80ff05 7f80fe02 7f80fe03 0
03 1 80007fff 7fff8000 80007fff 0
04 0 ff80ff01 ff8001ff ff808080 0
05 0 0310ff00 01200001 01f87fff 0
04 1 ffff0001 ffff0002 ffff0001 0
06 0 7f8010f0 01ff20f0 7f8030e0 1
06 0 01020304 10203040 11223344 0
07 1 80000005 00010007 8000fffe 1
08 0 ff018010 01018020 ff02ff30 1
09 1 0005ffff 00060001 0000fffe 1
09 0 ffffffff 01020304 fefdfcfb 0
0a 0 12345678 12005678 ff00ffff 0
0a 1 12345678 12345679 ffff0000 0
0b 0 807f0505 7f800605 ff00ff00 0
0e 0 807f0505 7f800605 00ffffff 0
0c 1 ffff0011 00000010 ffff0000 0
0d 1 ffff0001 00008000 0000ffff 0
0f 0 8010ff05 7f20fe05 8010fe05 0
12 1 80000001 7fff0002 80000002 0

// ==== bench/simd_alu_tb.sv ====
`timescale 1ns/1ns
// Testbench for the SIMD unit, run from the project root
// Records and their expected values come from bench/simd_alu_stimulus.txt
// NUM_RECORDS must match the number of records in that file
module simd_alu_tb
  import simd_op_pkg::*, simd_lane_pkg::*;
();

  localparam int NUM_RECORDS = 23;
  localparam int CYCLE_LIMIT = 8 * NUM_RECORDS + 20;

  logic        clk = 1'b0;
  logic        rst_n;
  logic        req;
  simd_op_e    op;
  lane_width_e width;
  simd_word_t  operand_a;
  simd_word_t  operand_b;
  logic        ack;
  simd_word_t  result;
  logic        ov;
  simd_word_t  exp_result;
  logic        exp_ov;
  int          value_errors;
  int          protocol_errors;

  logic [31:0] stim_mem [0:6*NUM_RECORDS-1];
  logic [31:0] rnd;
  int          cycles = 0;
  logic        timed_out = 1'b0;

  simd_alu_top simd_alu_top_i (
    .clk_i(clk), .rst_n_i(rst_n), .req_i(req), .op_i(op), .width_i(width),
    .operand_a_i(operand_a), .operand_b_i(operand_b), .ack_o(ack), .result_o(result),
    .ov_o(ov)
  );

  simd_alu_checker simd_alu_checker_i (
    .clk_i(clk), .rst_n_i(rst_n), .req_i(req), .ack_i(ack), .result_i(result), .ov_i(ov),
    .exp_result_i(exp_result), .exp_ov_i(exp_ov), .value_errors_o(value_errors),
    .protocol_errors_o(protocol_errors)
  );

  function automatic logic [31:0] next_random(input logic [31:0] x);
    logic [31:0] s;
    s = x ^ (x << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  initial begin
    forever begin
      #20 clk = ~clk;
    end
  end

  task automatic wait_ack(input logic level);
    do begin
      @(negedge clk);
    end while (ack != level);
  endtask

  // One four-phase exchange, idle gap and extra hold from the random stream
  task automatic apply_record(input int n);
    int gap;
    int hold;
    rnd  = next_random(rnd);
    gap  = int'(rnd[1:0]);
    hold = (rnd[2] && gap < 3) ? 1 : 0;
    repeat (gap) @(posedge clk);
    @(posedge clk);
    op         <= simd_op_e'(stim_mem[6*n][4:0]);
    width      <= lane_width_e'(stim_mem[6*n+1][0]);
    operand_a  <= stim_mem[6*n+2];
    operand_b  <= stim_mem[6*n+3];
    exp_result <= stim_mem[6*n+4];
    exp_ov     <= stim_mem[6*n+5][0];
    req        <= 1'b1;
    wait_ack(1'b1);
    repeat (hold) @(posedge clk);
    @(posedge clk);
    req <= 1'b0;
    wait_ack(1'b0);
  endtask

  task automatic finish_run();
    $display("Closing: %0d value errors, %0d protocol errors, %0d timeouts",
             value_errors, protocol_errors, timed_out);
    if (value_errors == 0 && protocol_errors == 0 && !timed_out) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence and cycle limit
  ////////////////////////////////////////////////////////////
  initial begin
    rst_n      = 1'b0;
    req        = 1'b0;
    op         = ADD;
    width      = W8;
    operand_a  = '0;
    operand_b  = '0;
    exp_result = '0;
    exp_ov     = 1'b0;
    rnd        = 32'h9318;
    $readmemh("bench/simd_alu_stimulus.txt", stim_mem);
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    for (int n = 0; n < NUM_RECORDS; n++) begin
      apply_record(n);
    end
    finish_run();
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout, the run did not finish within %0d clock cycles", CYCLE_LIMIT);
      timed_out = 1'b1;
      finish_run();
    end
  end

endmodule

// ==== bench/simd_alu_checker.sv ====
`timescale 1ns/1ns
// Watches the SIMD unit ports on the falling clock edge, where they are settled
// Expected values must be valid when ack_i rises
module simd_alu_checker
  import simd_lane_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  logic       req_i,
  input  logic       ack_i,
  input  simd_word_t result_i,
  input  logic       ov_i,
  input  simd_word_t exp_result_i,
  input  logic       exp_ov_i,
  output int         value_errors_o,
  output int         protocol_errors_o
);

  int         value_errors = 0;
  int         protocol_errors = 0;
  int         wait_cycles = 0;
  logic       ack_q = 1'b0;
  logic       req_q = 1'b0;
  simd_word_t held_result = '0;
  logic       held_ov = 1'b0;

  assign value_errors_o    = value_errors;
  assign protocol_errors_o = protocol_errors;

  task automatic compare_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
    if (actual !== expected) begin
      $display("[ERROR] %0t ns %s expected %08h got %08h", $time, name, expected, actual);
      value_errors++;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Handshake and result checks
  ////////////////////////////////////////////////////////////
  always @(negedge clk_i) begin
    if (!rst_n_i) begin
      if (ack_i !== 1'b0 || result_i !== '0 || ov_i !== 1'b0) begin
        $display("Protocol error at %0t ns, outputs not cleared by reset", $time);
        protocol_errors++;
      end
    end else if (ack_i && !ack_q) begin
      // Request raised two edges before ack
      if (wait_cycles != 2) begin
        $display("Protocol error at %0t ns, ack_o rose %0d cycles after req_i instead of 2",
                 $time, wait_cycles);
        protocol_errors++;
      end
      compare_value("result_o", exp_result_i, result_i);
      compare_value("ov_o", {31'b0, exp_ov_i}, {31'b0, ov_i});
      held_result = result_i;
      held_ov     = ov_i;
    end else if (ack_i && ack_q) begin
      if (!req_q) begin
        $display("Protocol error at %0t ns, ack_o still high after req_i dropped", $time);
        protocol_errors++;
      end else if (result_i !== held_result || ov_i !== held_ov) begin
        $display("Protocol error at %0t ns, result changed while req_i was held", $time);
        protocol_errors++;
      end
    end
    if (req_i && !ack_i) begin
      wait_cycles++;
    end else begin
      wait_cycles = 0;
    end
    ack_q = ack_i;
    req_q = req_i;
  end

endmodule

// ==== verilog/simd_alu_top.sv ====
`timescale 1ns/1ns
// Four-phase req/ack wrapper around the SIMD datapath
// One operation in flight, ack_o rises the edge after operand capture
// A new req_i must wait until ack_o is low
module simd_alu_top
  import simd_op_pkg::*, simd_lane_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic        req_i,
  input  simd_op_e    op_i,
  input  lane_width_e width_i,
  input  simd_word_t  operand_a_i,
  input  simd_word_t  operand_b_i,
  output logic        ack_o,
  output simd_word_t  result_o,
  output logic        ov_o
);

  typedef enum logic {ST_IDLE, ST_BUSY} state_e;

  state_e      state_q;
  simd_op_e    op_q;
  lane_width_e width_q;
  simd_word_t  a_q;
  simd_word_t  b_q;

  logic        sub, is_signed, width8, cmp_less, cmp_equal, cmp_invert, adder_ov;
  res_sel_e    res_sel;
  lane_sum_t   lane_sum;
  simd_word_t  sum, half, sat, cmp, minmax, result_d;

  // Capture on the edge that accepts a request
  always_ff @(posedge clk_i) begin
    if (state_q == ST_IDLE && req_i) begin
      op_q    <= op_i;
      width_q <= width_i;
      a_q     <= operand_a_i;
      b_q     <= operand_b_i;
    end
  end

  simd_op_decode simd_op_decode_i (
    .op_i(op_q), .width_i(width_q), .sub_o(sub), .signed_o(is_signed), .width8_o(width8),
    .res_sel_o(res_sel), .cmp_less_o(cmp_less), .cmp_equal_o(cmp_equal),
    .cmp_invert_o(cmp_invert)
  );

  simd_lane_adder simd_lane_adder_i (
    .operand_a_i(a_q), .operand_b_i(b_q), .sub_i(sub), .signed_i(is_signed),
    .width8_i(width8), .sum_o(sum), .half_o(half), .sat_o(sat), .lane_sum_o(lane_sum),
    .ov_o(adder_ov)
  );

  simd_lane_compare simd_lane_compare_i (
    .operand_a_i(a_q), .operand_b_i(b_q), .lane_sum_i(lane_sum), .signed_i(is_signed),
    .width8_i(width8), .cmp_less_i(cmp_less), .cmp_equal_i(cmp_equal),
    .cmp_invert_i(cmp_invert), .cmp_o(cmp), .minmax_o(minmax)
  );

  always_comb begin
    case (res_sel)
      HALF:    result_d = half;
      SAT:     result_d = sat;
      CMP:     result_d = cmp;
      MINMAX:  result_d = minmax;
      default: result_d = sum;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Handshake sequencer and result register
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q  <= ST_IDLE;
      ack_o    <= 1'b0;
      result_o <= '0;
      ov_o     <= 1'b0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (req_i) begin
            state_q <= ST_BUSY;
          end
        end
        default: begin
          if (!ack_o) begin
            ack_o    <= 1'b1;
            result_o <= result_d;
            // Overflow only reported by saturating ops
            ov_o     <= adder_ov & (res_sel == SAT);
          end else if (!req_i) begin
            ack_o   <= 1'b0;
            state_q <= ST_IDLE;
          end
        end
      endcase
    end
  end

endmodule

// ==== verilog/simd_lane_compare.sv ====
`timescale 1ns/1ns
// Lane comparator and min/max select, fed by the adder difference
// Valid only while the adder subtracts b from a
`include "simd_alu_defs.svh"

module simd_lane_compare
  import simd_lane_pkg::*;
(
  input  simd_word_t operand_a_i,
  input  simd_word_t operand_b_i,
  input  lane_sum_t  lane_sum_i,
  input  logic       signed_i,
  input  logic       width8_i,
  input  logic       cmp_less_i,
  input  logic       cmp_equal_i,
  input  logic       cmp_invert_i,
  output simd_word_t cmp_o,
  output simd_word_t minmax_o
);

  byte_flags_t eq_byte;
  byte_flags_t less_byte;
  byte_flags_t eq_lane;
  byte_flags_t less_lane;
  byte_flags_t mask;

  ////////////////////////////////////////////////////////////
  // Per-byte flags
  ////////////////////////////////////////////////////////////
  always_comb begin
    for (int i = 0; i < `SIMD_NBYTES; i++) begin
      eq_byte[i] = (lane_sum_i[i][7:0] == 8'h00);
      // Differing signs decide from a alone
      if (operand_a_i[8*i+7] ^ operand_b_i[8*i+7]) begin
        less_byte[i] = ~(operand_a_i[8*i+7] ^ signed_i);
      end else begin
        less_byte[i] = lane_sum_i[i][8];
      end
    end
  end

  // Halfword lanes: both bytes equal, less from the top byte
  assign eq_lane   = width8_i ? eq_byte : {{2{&eq_byte[3:2]}}, {2{&eq_byte[1:0]}}};
  assign less_lane = width8_i ? less_byte : {{2{less_byte[3]}}, {2{less_byte[1]}}};

  assign mask = ((less_lane & {`SIMD_NBYTES{cmp_less_i}}) |
                 (eq_lane & {`SIMD_NBYTES{cmp_equal_i}})) ^ {`SIMD_NBYTES{cmp_invert_i}};

  // Widen the mask and pick per byte
  always_comb begin
    for (int i = 0; i < `SIMD_NBYTES; i++) begin
      cmp_o[8*i +: 8]    = {8{mask[i]}};
      minmax_o[8*i +: 8] = mask[i] ? operand_a_i[8*i +: 8] : operand_b_i[8*i +: 8];
    end
  end

endmodule

// ==== verilog/simd_lane_adder.sv ====
`timescale 1ns/1ns
// Lane-splittable adder built from four 9-bit byte adders
// In 16-bit mode the carry crosses bytes 0-1 and 2-3 only
// Unsigned halving subtract yields a two's complement lane result
`include "simd_alu_defs.svh"

module simd_lane_adder
  import simd_lane_pkg::*;
(
  input  simd_word_t operand_a_i,
  input  simd_word_t operand_b_i,
  input  logic       sub_i,
  input  logic       signed_i,
  input  logic       width8_i,
  output simd_word_t sum_o,
  output simd_word_t half_o,
  output simd_word_t sat_o,
  output lane_sum_t  lane_sum_o,
  output logic       ov_o
);

  localparam logic [7:0]  S8_MIN  = `SIMD_SAT_S8_MIN;
  localparam logic [7:0]  S8_MAX  = `SIMD_SAT_S8_MAX;
  localparam logic [15:0] S16_MIN = `SIMD_SAT_S16_MIN;
  localparam logic [15:0] S16_MAX = `SIMD_SAT_S16_MAX;
  localparam logic [7:0]  U8_MAX  = `SIMD_SAT_U8_MAX;

  byte_flags_t clamp_byte;
  byte_flags_t clamp;
  byte_flags_t neg;

  ////////////////////////////////////////////////////////////
  // Byte adders
  ////////////////////////////////////////////////////////////
  always_comb begin
    logic       cin;
    logic [7:0] b_byte;
    logic [8:0] byte_add;
    logic       ext_a;
    logic       ext_b;
    cin = 1'b0;
    for (int i = 0; i < `SIMD_NBYTES; i++) begin
      // Lane bottom restarts the chain
      if (width8_i || (i % 2 == 0)) begin
        cin = sub_i;
      end
      b_byte   = operand_b_i[8*i +: 8] ^ {8{sub_i}};
      byte_add = {1'b0, operand_a_i[8*i +: 8]} + {1'b0, b_byte} + {8'h00, cin};
      // Extension bits of a and of the inverted b
      ext_a = signed_i & operand_a_i[8*i+7];
      ext_b = (signed_i & operand_b_i[8*i+7]) ^ sub_i;
      lane_sum_o[i] = {ext_a ^ ext_b ^ byte_add[8], byte_add[7:0]};
      sum_o[8*i +: 8] = byte_add[7:0];
      cin = byte_add[8];
    end
  end

  // Halving is the extended lane sum shifted right by one
  always_comb begin
    for (int i = 0; i < `SIMD_NBYTES; i++) begin
      half_o[8*i +: 8] = {(!width8_i && (i % 2 == 0)) ? lane_sum_o[i | 1][0] : lane_sum_o[i][8],
                          lane_sum_o[i][7:1]};
    end
  end

  ////////////////////////////////////////////////////////////
  // Saturation
  ////////////////////////////////////////////////////////////
  always_comb begin
    for (int i = 0; i < `SIMD_NBYTES; i++) begin
      clamp_byte[i] = signed_i ? (lane_sum_o[i][8] ^ lane_sum_o[i][7]) : lane_sum_o[i][8];
    end
    // 16-bit lanes follow their top byte
    for (int i = 0; i < `SIMD_NBYTES; i++) begin
      clamp[i] = width8_i ? clamp_byte[i] : clamp_byte[i | 1];
      neg[i]   = width8_i ? lane_sum_o[i][8] : lane_sum_o[i | 1][8];
    end
  end

  always_comb begin
    for (int i = 0; i < `SIMD_NBYTES; i++) begin
      if (!clamp[i]) begin
        sat_o[8*i +: 8] = lane_sum_o[i][7:0];
      end else if (!signed_i) begin
        sat_o[8*i +: 8] = sub_i ? 8'h00 : U8_MAX;
      end else if (width8_i) begin
        sat_o[8*i +: 8] = neg[i] ? S8_MIN : S8_MAX;
      end else begin
        sat_o[8*i +: 8] = neg[i] ? S16_MIN[8*(i%2) +: 8] : S16_MAX[8*(i%2) +: 8];
      end
    end
  end

  assign ov_o = |clamp;

endmodule

// ==== verilog/simd_op_decode.sv ====
`timescale 1ns/1ns
// Operation decoder of the SIMD unit, purely combinational
// Compare and min/max codes always subtract, the masks reuse the difference
module simd_op_decode
  import simd_op_pkg::*;
(
  input  simd_op_e    op_i,
  input  lane_width_e width_i,
  output logic        sub_o,
  output logic        signed_o,
  output logic        width8_o,
  output res_sel_e    res_sel_o,
  output logic        cmp_less_o,
  output logic        cmp_equal_o,
  output logic        cmp_invert_o
);

  // Adder control
  assign sub_o = op_i inside {SUB, RSUB, URSUB, KSUB, UKSUB, CMPEQ, SCMPLT, SCMPLE,
                              UCMPLT, UCMPLE, SMIN, SMAX, UMIN, UMAX};
  assign signed_o = op_i inside {RADD, RSUB, KADD, KSUB, SCMPLT, SCMPLE, SMIN, SMAX};
  assign width8_o = (width_i == W8);

  // Mask is (less | equal), inverted for max
  assign cmp_less_o   = op_i inside {SCMPLT, SCMPLE, UCMPLT, UCMPLE, SMIN, SMAX, UMIN, UMAX};
  assign cmp_equal_o  = op_i inside {CMPEQ, SCMPLE, UCMPLE, SMAX, UMAX};
  assign cmp_invert_o = op_i inside {SMAX, UMAX};

  ////////////////////////////////////////////////////////////
  // Result source
  ////////////////////////////////////////////////////////////
  always_comb begin
    case (op_i)
      RADD, RSUB, URADD, URSUB: res_sel_o = HALF;
      KADD, KSUB, UKADD, UKSUB: res_sel_o = SAT;
      CMPEQ, SCMPLT, SCMPLE,
      UCMPLT, UCMPLE:           res_sel_o = CMP;
      SMIN, SMAX, UMIN, UMAX:   res_sel_o = MINMAX;
      default:                  res_sel_o = SUM;
    endcase
  end

endmodule

// ==== verilog/simd_lane_pkg.sv ====
// Data layout types of the SIMD datapath
// Lane sums are indexed by byte, bit 8 is the extended sign or carry
`include "simd_alu_defs.svh"

package simd_lane_pkg;

  // One data word
  typedef logic [`SIMD_XLEN-1:0] simd_word_t;

  // One flag per byte lane
  typedef logic [`SIMD_NBYTES-1:0] byte_flags_t;

  // Extended 9-bit sum of every byte adder
  typedef logic [`SIMD_NBYTES-1:0][8:0] lane_sum_t;

endpackage

// ==== verilog/simd_op_pkg.sv ====
// Instruction encodings of the SIMD unit
// Codes above UMAX are not decoded and fall back to a wrapping add
package simd_op_pkg;

  // Operation code
  typedef enum logic [4:0] {
    ADD    = 5'd0,  SUB    = 5'd1,
    RADD   = 5'd2,  RSUB   = 5'd3,
    URADD  = 5'd4,  URSUB  = 5'd5,
    KADD   = 5'd6,  KSUB   = 5'd7,
    UKADD  = 5'd8,  UKSUB  = 5'd9,
    CMPEQ  = 5'd10,
    SCMPLT = 5'd11, SCMPLE = 5'd12,
    UCMPLT = 5'd13, UCMPLE = 5'd14,
    SMIN   = 5'd15, SMAX   = 5'd16,
    UMIN   = 5'd17, UMAX   = 5'd18
  } simd_op_e;

  // Lane width
  typedef enum logic {
    W8  = 1'b0,
    W16 = 1'b1
  } lane_width_e;

  // Result source, five sources need three bits
  typedef enum logic [2:0] {
    SUM, HALF, SAT, CMP, MINMAX
  } res_sel_e;

endpackage

// ==== verilog/simd_alu_defs.svh ====
// Word geometry and saturation limits of the packed-SIMD unit
// Limits are raw two's complement bit patterns of the lane width
`ifndef SIMD_ALU_DEFS_SVH
`define SIMD_ALU_DEFS_SVH

// Word and lane geometry
`define SIMD_XLEN   32
`define SIMD_NBYTES 4

// Signed and unsigned clamp values
`define SIMD_SAT_S8_MIN  8'h80
`define SIMD_SAT_S8_MAX  8'h7f
`define SIMD_SAT_S16_MIN 16'h8000
`define SIMD_SAT_S16_MAX 16'h7fff
`define SIMD_SAT_U8_MAX  8'hff

`endif
